//--- verification/program_input.txt
// Line 1: program words, write events, store events, instructions to retire
// Then program words, write events as (reg data), store events as (addr data)
00000019 0000000E 00000002 00000015
2401FFFB 34028005 00221821 00412023  // addiu r1 -5, ori r2, addu, subu
00222824 00223025 00223826 0022402A  // and, or, xor, slt with negative rs
0041482A 240A0100 AD470008 8D4B0008  // slt, base 0x100, sw r7, lw r11
11670001 240C0BAD 10220001 240D0123  // beq taken, skipped, beq not taken, addiu r13
08000014 240E0DEA FC000000 240F0777  // j 0x50 and three skipped words
24000055 000D7821 AD40000C FC000000  // write r0, read r0, store r0, undefined op
1000FFFF                             // Halt loop
01 FFFFFFFB 02 00008005 03 00008000 04 0000800A
05 00008001 06 FFFFFFFF 07 FFFF7FFE 08 00000001
09 00000000 0A 00000100 0B FFFF7FFE 0D 00000123
00 00000055 0F 00000123
00000108 FFFF7FFE 0000010C 00000000

//--- mips_multicycle.f
+incdir+hw
hw/mips_pkg.sv
hw/control_fsm.sv
hw/pc_unit.sv
hw/reg_file.sv
hw/alu_stage.sv
hw/mem_unit.sv
hw/mips_multicycle.sv
verification/mips_multicycle_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mips_multicycle.f \
    --top-module mips_multicycle_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmips_multicycle_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

//--- verification/mips_multicycle_tb.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module mips_multicycle_tb;

    logic               clk = 1'b0;
    logic               reset;
    logic               load_en;
    logic [`MEM_AW-1:0] load_addr;
    logic [`DATA_W-1:0] load_data;
    logic               wb_valid;
    logic [4:0]         wb_reg;
    logic [`DATA_W-1:0] wb_data;
    logic               st_valid;
    logic [`DATA_W-1:0] st_addr;
    logic [`DATA_W-1:0] st_data;
    logic               retire;

    logic [`DATA_W-1:0] stim [256];   // Counts, program, then expected events
    int n_prog;
    int n_wb;
    int n_st;
    int n_instr;
    int wb_base;
    int st_base;
    bit quiet          = 1'b0;        // No write, store or retire allowed
    bit running        = 1'b0;
    int wb_seen        = 0;
    int st_seen        = 0;
    int retired        = 0;
    int since_retire   = 0;           // Cycles since reset release or the last retire
    int value_errors   = 0;
    int extra_events   = 0;
    int missing_events = 0;
    int timing_errors  = 0;

    mips_multicycle UUT (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data), .retire(retire)
    );

    always #50 clk = ~clk;

    function automatic logic [`DATA_W-1:0] stim_word(input int idx);
        return stim[idx[7:0]];
    endfunction

    task automatic check_wb(input logic [4:0] reg_got, input logic [`DATA_W-1:0] data_got);
        logic [`DATA_W-1:0] reg_word;
        logic [`DATA_W-1:0] data_exp;
        if (wb_seen >= n_wb) begin
            $display("Unexpected write to r%0d at %0t ns after all expected writes",
                     reg_got, $time);
            extra_events++;
        end else begin
            reg_word = stim_word(wb_base + 2 * wb_seen);
            data_exp = stim_word(wb_base + 2 * wb_seen + 1);
            if (reg_got !== reg_word[4:0] || data_got !== data_exp) begin
                $display("FAILED at %0t ns: write %0d gave r%0d = %h, expected r%0d = %h",
                         $time, wb_seen, reg_got, data_got, reg_word[4:0], data_exp);
                value_errors++;
            end
        end
        wb_seen++;
    endtask

    task automatic check_st(input logic [`DATA_W-1:0] addr_got,
                            input logic [`DATA_W-1:0] data_got);
        logic [`DATA_W-1:0] addr_exp;
        logic [`DATA_W-1:0] data_exp;
        if (st_seen >= n_st) begin
            $display("Unexpected store to %h at %0t ns after all expected stores",
                     addr_got, $time);
            extra_events++;
        end else begin
            addr_exp = stim_word(st_base + 2 * st_seen);
            data_exp = stim_word(st_base + 2 * st_seen + 1);
            if (addr_got !== addr_exp || data_got !== data_exp) begin
                $display("FAILED at %0t ns: store %0d gave [%h] = %h, expected [%h] = %h",
                         $time, st_seen, addr_got, data_got, addr_exp, data_exp);
                value_errors++;
            end
        end
        st_seen++;
    endtask

    // Outputs settle mid-cycle
    always @(negedge clk) begin
        if (quiet && (wb_valid || st_valid || retire)) begin
            $display("A write, store or retire pulse came at %0t ns before the first fetch ended",
                     $time);
            extra_events++;
        end
        if (running) begin
            since_retire++;
            // Writes and stores happen only in the last state of an instruction
            if ((wb_valid || st_valid) && !retire) begin
                $display("A write or store came at %0t ns without a retire pulse", $time);
                timing_errors++;
            end
            if (wb_valid) begin
                check_wb(wb_reg, wb_data);
            end
            if (st_valid) begin
                check_st(st_addr, st_data);
            end
            if (retire) begin
                // Every instruction takes three or four cycles
                if (since_retire < 3 || since_retire > 4) begin
                    $display("Retire came at %0t ns only %0d cycles after the previous one",
                             $time, since_retire);
                    timing_errors++;
                end
                since_retire = 0;
                retired++;
            end
        end
    end

    initial begin
        reset     <= 1'b1;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        $readmemh("verification/program_input.txt", stim);
        n_prog  = stim[0];
        n_wb    = stim[1];
        n_st    = stim[2];
        n_instr = stim[3];
        wb_base = 4 + n_prog;
        st_base = wb_base + 2 * n_wb;
        @(posedge clk);
        quiet = 1'b1;
        // Reset spans the program load and two idle cycles after it
        for (int i = 0; i < n_prog; i++) begin
            load_en   <= 1'b1;
            load_addr <= i[`MEM_AW-1:0];
            load_data <= stim_word(4 + i);
            @(posedge clk);
        end
        load_en <= 1'b0;
        repeat (2) @(posedge clk);
        reset   <= 1'b0;
        running = 1'b1;
        @(posedge clk);                 // First FETCH done
        quiet = 1'b0;
        if (n_instr == 0) begin
            $display("The data file is missing or lists no instructions");
            missing_events++;
        end
        while (retired < n_instr) begin
            @(posedge clk);
        end
        if (wb_seen < n_wb) begin
            $display("Only %0d of %0d register writes were seen", wb_seen, n_wb);
            missing_events += n_wb - wb_seen;
        end
        if (st_seen < n_st) begin
            $display("Only %0d of %0d stores were seen", st_seen, n_st);
            missing_events += n_st - st_seen;
        end
        $display("Errors: %0d mismatched, %0d unexpected, %0d missing, %0d timing",
                 value_errors, extra_events, missing_events, timing_errors);
        if (value_errors == 0 && extra_events == 0 && missing_events == 0 &&
            timing_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Four cycles per instruction cover the longest instruction
    initial begin
        wait (running);
        repeat (4 * n_instr + 20) @(posedge clk);
        $display("Timeout with %0d of %0d instructions retired", retired, n_instr);
        $display("Errors: %0d mismatched, %0d unexpected, %0d missing, %0d timing",
                 value_errors, extra_events, missing_events, timing_errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- hw/mips_multicycle.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module mips_multicycle (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_en,
    input  logic [`MEM_AW-1:0] load_addr,
    input  logic [`DATA_W-1:0] load_data,
    output logic               wb_valid,
    output logic [4:0]         wb_reg,
    output logic [`DATA_W-1:0] wb_data,
    output logic               st_valid,
    output logic [`DATA_W-1:0] st_addr,
    output logic [`DATA_W-1:0] st_data,
    output logic               retire
);

    mips_pkg::instr_u   instr;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] alu_result;
    logic [`DATA_W-1:0] alu_out;
    logic [`DATA_W-1:0] mem_rdata;
    logic               zero;
    logic               ir_write;
    logic               pc_write;
    logic               pc_branch;
    logic [1:0]         pc_src;
    logic               alu_src_a;
    logic [1:0]         alu_src_b;
    logic [2:0]         alu_op;
    logic               reg_write;
    logic               reg_dest;
    logic               reg_data_sel;
    logic               mem_write;
    logic               iod;

    assign wb_valid = reg_write;
    assign st_valid = mem_write;
    assign st_addr  = alu_out;   // Store address and data as seen by memory
    assign st_data  = b;

    control_fsm u_ctrl (
        .clk(clk), .reset(reset), .instr(instr), .zero(zero),
        .ir_write(ir_write), .pc_write(pc_write), .pc_branch(pc_branch),
        .pc_src(pc_src), .alu_src_a(alu_src_a), .alu_src_b(alu_src_b),
        .alu_op(alu_op), .reg_write(reg_write), .reg_dest(reg_dest),
        .reg_data_sel(reg_data_sel), .mem_write(mem_write), .iod(iod),
        .retire(retire)
    );

    pc_unit u_pc (
        .clk(clk), .reset(reset), .pc_write(pc_write), .pc_branch(pc_branch),
        .zero(zero), .pc_src(pc_src), .alu_result(alu_result), .alu_out(alu_out),
        .target(instr.j.target), .pc(pc)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset), .instr(instr), .reg_write(reg_write),
        .reg_dest(reg_dest), .reg_data_sel(reg_data_sel), .alu_result(alu_result),
        .mem_rdata(mem_rdata), .a(a), .b(b), .wb_data(wb_data), .wb_reg(wb_reg)
    );

    alu_stage u_alu (
        .clk(clk), .reset(reset), .instr(instr), .alu_src_a(alu_src_a),
        .alu_src_b(alu_src_b), .alu_op(alu_op), .pc(pc), .a(a), .b(b),
        .alu_result(alu_result), .alu_out(alu_out), .zero(zero)
    );

    mem_unit u_mem (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .iod(iod), .ir_write(ir_write),
        .mem_write(mem_write), .pc(pc), .alu_out(alu_out), .b(b),
        .instr(instr), .mem_rdata(mem_rdata)
    );

endmodule

//--- hw/mem_unit.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module mem_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_en,
    input  logic [`MEM_AW-1:0] load_addr,
    input  logic [`DATA_W-1:0] load_data,
    input  logic               iod,
    input  logic               ir_write,
    input  logic               mem_write,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] alu_out,
    input  logic [`DATA_W-1:0] b,
    output mips_pkg::instr_u   instr,
    output logic [`DATA_W-1:0] mem_rdata
);

    logic [`DATA_W-1:0] mem [`MEM_WORDS];
    logic [`MEM_AW-1:0] addr;

    // Word index from byte address, data side when iod is set
    assign addr      = iod ? alu_out[`MEM_AW+1:2] : pc[`MEM_AW+1:2];
    assign mem_rdata = mem[addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            if (load_en) begin
                mem[load_addr] <= load_data;  // Program load
            end
        end else if (mem_write) begin
            mem[addr] <= b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (ir_write) begin
            instr <= mem_rdata;
        end
    end

    // The load port owns the memory while reset is high
    assert property (@(posedge clk) reset |-> !mem_write);

endmodule

//--- hw/alu_stage.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module alu_stage (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::instr_u   instr,
    input  logic               alu_src_a,
    input  logic [1:0]         alu_src_b,
    input  logic [2:0]         alu_op,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic [`DATA_W-1:0] alu_result,
    output logic [`DATA_W-1:0] alu_out,
    output logic               zero
);

    logic [`DATA_W-1:0] src_a;
    logic [`DATA_W-1:0] src_b;
    logic [`DATA_W-1:0] imm_sext;
    logic [`DATA_W-1:0] imm_ext;

    assign imm_sext = {{(`DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
    // ORI takes its immediate unsigned
    assign imm_ext  = (instr.i.op == `OP_ORI) ? {{(`DATA_W-16){1'b0}}, instr.i.imm}
                                              : imm_sext;

    assign src_a = alu_src_a ? a : pc;

    always_comb begin
        case (alu_src_b)
            2'd0:    src_b = b;
            2'd1:    src_b = `DATA_W'(4);
            2'd2:    src_b = imm_ext;
            default: src_b = {imm_sext[`DATA_W-3:0], 2'b00}; // Word offset
        endcase
    end

    always_comb begin
        case (alu_op)
            `ALU_SUB: alu_result = src_a - src_b;
            `ALU_AND: alu_result = src_a & src_b;
            `ALU_OR:  alu_result = src_a | src_b;
            `ALU_XOR: alu_result = src_a ^ src_b;
            `ALU_SLT: alu_result = {{(`DATA_W-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            default:  alu_result = src_a + src_b;
        endcase
    end

    assign zero = (alu_result == '0);  // BEQ compares through SUB

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_out <= '0;
        end else begin
            alu_out <= alu_result;
        end
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::instr_u   instr,
    input  logic               reg_write,
    input  logic               reg_dest,
    input  logic               reg_data_sel,
    input  logic [`DATA_W-1:0] alu_result,
    input  logic [`DATA_W-1:0] mem_rdata,
    output logic [`DATA_W-1:0] a,
    output logic [`DATA_W-1:0] b,
    output logic [`DATA_W-1:0] wb_data,
    output logic [4:0]         wb_reg
);

    logic [`DATA_W-1:0] regs [32];

    assign wb_reg  = reg_dest ? instr.r.rd : instr.r.rt;     // rd for R-type
    assign wb_data = reg_data_sel ? mem_rdata : alu_result;  // Load data or ALU

    always_ff @(posedge clk) begin
        if (reg_write && (wb_reg != 5'd0)) begin
            regs[wb_reg] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a <= '0;
            b <= '0;
        end else begin
            a <= (instr.r.rs == 5'd0) ? '0 : regs[instr.r.rs]; // $zero reads as 0
            b <= (instr.r.rt == 5'd0) ? '0 : regs[instr.r.rt];
        end
    end

endmodule

//--- hw/pc_unit.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module pc_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              pc_write,
    input  logic              pc_branch,
    input  logic              zero,
    input  logic [1:0]        pc_src,
    input  logic [`DATA_W-1:0] alu_result,
    input  logic [`DATA_W-1:0] alu_out,
    input  logic [25:0]       target,
    output logic [`DATA_W-1:0] pc
);

    logic [`DATA_W-1:0] pc_next;

    always_comb begin
        case (pc_src)
            2'd1:    pc_next = alu_out;                                   // Branch target
            2'd2:    pc_next = {pc[`DATA_W-1:`DATA_W-4], target, 2'b00}; // Jump
            default: pc_next = alu_result;                                // pc + 4
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_write || (pc_branch && zero)) begin
            pc <= pc_next;
        end
    end

    // Increment, branch and jump targets all land on word boundaries
    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- hw/control_fsm.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module control_fsm (
    input  logic             clk,
    input  logic             reset,
    input  mips_pkg::instr_u instr,
    input  logic             zero,
    output logic             ir_write,
    output logic             pc_write,
    output logic             pc_branch,
    output logic [1:0]       pc_src,
    output logic             alu_src_a,
    output logic [1:0]       alu_src_b,
    output logic [2:0]       alu_op,
    output logic             reg_write,
    output logic             reg_dest,
    output logic             reg_data_sel,
    output logic             mem_write,
    output logic             iod,
    output logic             retire
);

    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        DECODE  = 2'd1,
        EXECUTE = 2'd2,
        MEMORY  = 2'd3
    } state_t;

    state_t state;
    logic   is_mem_op;

    assign is_mem_op = (instr.i.op == `OP_LW) || (instr.i.op == `OP_SW);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH:   state <= DECODE;
                DECODE:  state <= EXECUTE;
                EXECUTE: state <= is_mem_op ? MEMORY : FETCH; // Only loads and stores go on
                default: state <= FETCH;
            endcase
        end
    end

    always_comb begin
        ir_write     = 1'b0;
        pc_write     = 1'b0;
        pc_branch    = 1'b0;
        pc_src       = 2'd0;
        alu_src_a    = 1'b0;
        alu_src_b    = 2'd0;
        alu_op       = `ALU_ADD;
        reg_write    = 1'b0;
        reg_dest     = 1'b0;
        reg_data_sel = 1'b0;
        mem_write    = 1'b0;
        iod          = 1'b0;
        retire       = 1'b0;
        case (state)
            FETCH: begin
                ir_write  = 1'b1;
                pc_write  = 1'b1;
                alu_src_b = 2'd1;                   // pc + 4
            end
            DECODE: begin
                alu_src_b = 2'd3;                   // Branch target into alu_out
            end
            EXECUTE: begin
                alu_src_a = 1'b1;
                retire    = !is_mem_op;
                case (instr.r.op)
                    `OP_RTYPE: begin
                        reg_write = 1'b1;
                        reg_dest  = 1'b1;           // Write rd
                        case (instr.r.funct)
                            `FN_ADDU: alu_op = `ALU_ADD;
                            `FN_SUBU: alu_op = `ALU_SUB;
                            `FN_AND:  alu_op = `ALU_AND;
                            `FN_OR:   alu_op = `ALU_OR;
                            `FN_XOR:  alu_op = `ALU_XOR;
                            `FN_SLT:  alu_op = `ALU_SLT;
                            default:  reg_write = 1'b0; // Unknown funct does nothing
                        endcase
                    end
                    `OP_ADDIU: begin
                        alu_src_b = 2'd2;
                        reg_write = 1'b1;
                    end
                    `OP_ORI: begin
                        alu_src_b = 2'd2;
                        alu_op    = `ALU_OR;
                        reg_write = 1'b1;
                    end
                    `OP_LW, `OP_SW: begin
                        alu_src_b = 2'd2;           // Effective address
                    end
                    `OP_BEQ: begin
                        alu_op    = `ALU_SUB;
                        pc_src    = 2'd1;
                        pc_branch = zero;           // Taken only when a equals b
                    end
                    `OP_J: begin
                        pc_src   = 2'd2;
                        pc_write = 1'b1;
                    end
                    default: reg_write = 1'b0;      // Undefined opcode is a no-op
                endcase
            end
            default: begin                          // MEMORY
                iod    = 1'b1;
                retire = 1'b1;
                if (instr.i.op == `OP_LW) begin
                    reg_write    = 1'b1;
                    reg_data_sel = 1'b1;
                end else begin
                    mem_write = 1'b1;
                end
            end
        endcase
    end

    // A store must never coincide with an instruction fetch
    assert property (@(posedge clk) disable iff (reset) !(mem_write && ir_write));

    assert property (@(posedge clk) disable iff (reset) !reset |=> state != $past(state));

endmodule

//--- hw/mips_pkg.sv
package mips_pkg;

    // One instruction word, decoded as R, I or J format
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target;
        } j;
    } instr_u;

endpackage

//--- hw/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath and memory sizes
`define DATA_W    32
`define MEM_WORDS 256
`define MEM_AW    8

// Primary opcodes
`define OP_RTYPE  6'b000000
`define OP_J      6'b000010
`define OP_BEQ    6'b000100
`define OP_ADDIU  6'b001001
`define OP_ORI    6'b001101
`define OP_LW     6'b100011
`define OP_SW     6'b101011

// Function codes for R-type
`define FN_ADDU   6'b100001
`define FN_SUBU   6'b100011
`define FN_AND    6'b100100
`define FN_OR     6'b100101
`define FN_XOR    6'b100110
`define FN_SLT    6'b101010

// ALU operations
`define ALU_ADD   3'd0
`define ALU_SUB   3'd1
`define ALU_AND   3'd2
`define ALU_OR    3'd3
`define ALU_XOR   3'd4
`define ALU_SLT   3'd5

`endif
